/* logic/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // ------------------------------------------------------------------------
    // major opcodes
    // ------------------------------------------------------------------------
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_system = 7'b1110011;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
    } alu_op_t;

    typedef enum logic [1:0] {wb_alu, wb_load, wb_pc4, wb_imm} wb_sel_t;

    typedef enum logic [1:0] {fwd_rf, fwd_mem, fwd_wb} fwd_sel_t;

    // ------------------------------------------------------------------------
    // stage payloads
    // ------------------------------------------------------------------------
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fd_payload_t;

    typedef struct packed {
        word_t     pc;
        word_t     rdata1;
        word_t     rdata2;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic [2:0] funct3;
        alu_op_t   alu_op;
        logic      use_imm;
        wb_sel_t   wb_sel;
        logic      reg_we;
        logic      mem_read;
        logic      mem_write;
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
        logic      is_ebreak;
    } de_payload_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
        wb_sel_t   wb_sel;
        logic      reg_we;
        logic      mem_read;
        logic      mem_write;
        logic      is_ebreak;
    } em_payload_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        word_t     load_data;
        reg_addr_t rd;
        wb_sel_t   wb_sel;
        logic      reg_we;
        logic      is_ebreak;
    } mw_payload_t;

endpackage

/* logic/stage_reg.sv */
module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // flush wins over hold
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

    // a squashed slot never shows up downstream
    assert property (@(posedge clk) flush |=> !out_valid)
        else $error("stage_reg: valid after flush");

endmodule

/* logic/instr_decoder.sv */
module instr_decoder (
    input  rv_pkg::word_t     instr,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::word_t     imm,
    output rv_pkg::alu_op_t   alu_op,
    output logic              use_imm,
    output rv_pkg::wb_sel_t   wb_sel,
    output logic              reg_we,
    output logic              uses_rs1,
    output logic              uses_rs2,
    output logic              mem_read,
    output logic              mem_write,
    output logic              is_branch,
    output logic              is_jal,
    output logic              is_jalr,
    output logic              is_ebreak
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_u;
    rv_pkg::word_t imm_j;

    function automatic rv_pkg::alu_op_t alu_from_funct(
        input logic [2:0] f3,
        input logic       alt,
        input logic       allow_sub
    );
        case (f3)
            3'b000:  return (allow_sub && alt) ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  return rv_pkg::alu_sll;
            3'b010:  return rv_pkg::alu_slt;
            3'b011:  return rv_pkg::alu_sltu;
            3'b100:  return rv_pkg::alu_xor;
            3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  return rv_pkg::alu_or;
            default: return rv_pkg::alu_and;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // anything not matched below behaves as a nop
        imm       = imm_i;
        alu_op    = rv_pkg::alu_add;
        use_imm   = 1'b0;
        wb_sel    = rv_pkg::wb_alu;
        reg_we    = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        is_ebreak = 1'b0;
        case (opcode)
            rv_pkg::op_reg: begin
                alu_op   = alu_from_funct(funct3, instr[30], 1'b1);
                reg_we   = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            rv_pkg::op_imm: begin
                alu_op   = alu_from_funct(funct3, instr[30], 1'b0);
                use_imm  = 1'b1;
                reg_we   = 1'b1;
                uses_rs1 = 1'b1;
            end
            rv_pkg::op_lui: begin
                imm    = imm_u;
                wb_sel = rv_pkg::wb_imm;
                reg_we = 1'b1;
            end
            rv_pkg::op_load: begin
                // word access only
                if (funct3 == 3'b010) begin
                    use_imm  = 1'b1;
                    wb_sel   = rv_pkg::wb_load;
                    reg_we   = 1'b1;
                    uses_rs1 = 1'b1;
                    mem_read = 1'b1;
                end
            end
            rv_pkg::op_store: begin
                if (funct3 == 3'b010) begin
                    imm       = imm_s;
                    use_imm   = 1'b1;
                    uses_rs1  = 1'b1;
                    uses_rs2  = 1'b1;
                    mem_write = 1'b1;
                end
            end
            rv_pkg::op_branch: begin
                if (funct3 != 3'b010 && funct3 != 3'b011) begin
                    imm       = imm_b;
                    uses_rs1  = 1'b1;
                    uses_rs2  = 1'b1;
                    is_branch = 1'b1;
                end
            end
            rv_pkg::op_jal: begin
                imm    = imm_j;
                wb_sel = rv_pkg::wb_pc4;
                reg_we = 1'b1;
                is_jal = 1'b1;
            end
            rv_pkg::op_jalr: begin
                wb_sel   = rv_pkg::wb_pc4;
                reg_we   = 1'b1;
                uses_rs1 = 1'b1;
                is_jalr  = 1'b1;
            end
            rv_pkg::op_system: begin
                is_ebreak = (instr[31:20] == 12'h001) && (instr[19:7] == '0);
            end
            default: ;
        endcase
    end

endmodule

/* logic/register_file.sv */
module register_file (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);

    rv_pkg::word_t regs [0:31];
    logic          wr_en;

    // x0 is never written, so regs[0] stays zero after reset
    assign wr_en = we && (waddr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write passes straight to the readers
    assign rdata1 = (wr_en && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (wr_en && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

/* logic/execute_unit.sv */
module execute_unit (
    input  rv_pkg::word_t    pc,
    input  rv_pkg::word_t    rdata1,
    input  rv_pkg::word_t    rdata2,
    input  rv_pkg::word_t    imm,
    input  rv_pkg::alu_op_t  alu_op,
    input  logic             use_imm,
    input  logic [2:0]       funct3,
    input  logic             is_branch,
    input  logic             is_jal,
    input  logic             is_jalr,
    input  logic             valid,
    input  rv_pkg::fwd_sel_t fwd_a,
    input  rv_pkg::fwd_sel_t fwd_b,
    input  rv_pkg::word_t    mem_result,
    input  rv_pkg::word_t    wb_result,
    output rv_pkg::word_t    alu_result,
    output rv_pkg::word_t    store_data,
    output logic             redirect,
    output rv_pkg::word_t    redirect_pc
);

    rv_pkg::word_t op_a;
    rv_pkg::word_t op_rs2;
    rv_pkg::word_t op_b;
    rv_pkg::word_t jalr_sum;
    logic          taken;

    // ------------------------------------------------------------------------
    // operand forwarding
    // ------------------------------------------------------------------------
    always_comb begin
        case (fwd_a)
            rv_pkg::fwd_mem: op_a = mem_result;
            rv_pkg::fwd_wb:  op_a = wb_result;
            default:         op_a = rdata1;
        endcase
        case (fwd_b)
            rv_pkg::fwd_mem: op_rs2 = mem_result;
            rv_pkg::fwd_wb:  op_rs2 = wb_result;
            default:         op_rs2 = rdata2;
        endcase
    end

    assign op_b       = use_imm ? imm : op_rs2;
    assign store_data = op_rs2;

    always_comb begin
        case (alu_op)
            rv_pkg::alu_sub:  alu_result = op_a - op_b;
            rv_pkg::alu_and:  alu_result = op_a & op_b;
            rv_pkg::alu_or:   alu_result = op_a | op_b;
            rv_pkg::alu_xor:  alu_result = op_a ^ op_b;
            rv_pkg::alu_slt:  alu_result = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
            rv_pkg::alu_sltu: alu_result = rv_pkg::word_t'(op_a < op_b);
            rv_pkg::alu_sll:  alu_result = op_a << op_b[4:0];
            rv_pkg::alu_srl:  alu_result = op_a >> op_b[4:0];
            rv_pkg::alu_sra:  alu_result = rv_pkg::word_t'($signed(op_a) >>> op_b[4:0]);
            default:          alu_result = op_a + op_b;
        endcase
    end

    // ------------------------------------------------------------------------
    // branch condition and target
    // ------------------------------------------------------------------------
    always_comb begin
        case (funct3)
            3'b000:  taken = (op_a == op_rs2);
            3'b001:  taken = (op_a != op_rs2);
            3'b100:  taken = ($signed(op_a) < $signed(op_rs2));
            3'b101:  taken = ($signed(op_a) >= $signed(op_rs2));
            3'b110:  taken = (op_a < op_rs2);
            3'b111:  taken = (op_a >= op_rs2);
            default: taken = 1'b0;
        endcase
    end

    assign jalr_sum    = op_a + imm;
    assign redirect    = valid && (is_jal || is_jalr || (is_branch && taken));
    assign redirect_pc = is_jalr ? {jalr_sum[31:1], 1'b0} : pc + imm;

endmodule

/* logic/hazard_unit.sv */
module hazard_unit (
    input  rv_pkg::reg_addr_t d_rs1,
    input  rv_pkg::reg_addr_t d_rs2,
    input  logic              d_uses_rs1,
    input  logic              d_uses_rs2,
    input  rv_pkg::reg_addr_t e_rs1,
    input  rv_pkg::reg_addr_t e_rs2,
    input  rv_pkg::reg_addr_t e_rd,
    input  logic              e_valid,
    input  logic              e_mem_read,
    input  rv_pkg::reg_addr_t m_rd,
    input  logic              m_valid,
    input  logic              m_reg_we,
    input  rv_pkg::reg_addr_t w_rd,
    input  logic              w_valid,
    input  logic              w_reg_we,
    input  logic              redirect,
    output logic              stall,
    output logic              flush_fd,
    output logic              flush_de,
    output rv_pkg::fwd_sel_t  fwd_a,
    output rv_pkg::fwd_sel_t  fwd_b
);

    logic load_in_e;

    // youngest producer first
    function automatic rv_pkg::fwd_sel_t pick(input rv_pkg::reg_addr_t rs);
        if (m_valid && m_reg_we && m_rd != '0 && m_rd == rs) begin
            return rv_pkg::fwd_mem;
        end
        if (w_valid && w_reg_we && w_rd != '0 && w_rd == rs) begin
            return rv_pkg::fwd_wb;
        end
        return rv_pkg::fwd_rf;
    endfunction

    always_comb begin
        fwd_a = pick(e_rs1);
        fwd_b = pick(e_rs2);
    end

    // load result is only ready once the load reaches memory
    assign load_in_e = e_valid && e_mem_read && (e_rd != '0);
    assign stall     = load_in_e && ((d_uses_rs1 && d_rs1 == e_rd) ||
                                     (d_uses_rs2 && d_rs2 == e_rd));

    assign flush_fd = redirect;
    assign flush_de = redirect || stall;

    always_comb begin
        assert final (!(stall && redirect))
            else $error("hazard_unit: stall and redirect together");
    end

endmodule

/* logic/rv_core.sv */
module rv_core #(
    parameter rv_pkg::word_t reset_pc = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::word_t     imem_data,
    input  rv_pkg::word_t     dmem_rdata,
    output rv_pkg::word_t     imem_addr,
    output rv_pkg::word_t     dmem_addr,
    output rv_pkg::word_t     dmem_wdata,
    output logic              dmem_we,
    output logic              retire_valid,
    output rv_pkg::word_t     retire_pc,
    output rv_pkg::reg_addr_t retire_rd,
    output rv_pkg::word_t     retire_data,
    output logic              halt
);

    rv_pkg::word_t       pc;
    logic                stall, flush_fd, flush_de, redirect;
    rv_pkg::word_t       redirect_pc;
    rv_pkg::fwd_sel_t    fwd_a, fwd_b;
    logic                stop_r, halt_r, e_ebreak;
    rv_pkg::fd_payload_t fd_in, fd_q;
    rv_pkg::de_payload_t de_in, de_q;
    rv_pkg::em_payload_t em_in, em_q;
    rv_pkg::mw_payload_t mw_in, mw_q;
    logic                fd_valid, de_valid, em_valid, mw_valid;
    rv_pkg::reg_addr_t   d_rs1, d_rs2, d_rd;
    rv_pkg::word_t       d_imm, d_rdata1, d_rdata2;
    rv_pkg::alu_op_t     d_alu_op;
    rv_pkg::wb_sel_t     d_wb_sel;
    logic                d_use_imm, d_reg_we, d_uses_rs1, d_uses_rs2;
    logic                d_mem_read, d_mem_write, d_is_branch;
    logic                d_is_jal, d_is_jalr, d_is_ebreak;
    rv_pkg::word_t       alu_result, store_data, mem_result, wb_value;

    // ------------------------------------------------------------------------
    // fetch
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall && !stop_r) begin
            pc <= pc + 32'd4;
        end
    end

    // ebreak in execute drains the younger slots and fetch stops for good
    assign e_ebreak = de_valid && de_q.is_ebreak;

    always_ff @(posedge clk) begin
        if (rst) begin
            stop_r <= 1'b0;
            halt_r <= 1'b0;
        end else begin
            if (e_ebreak) begin
                stop_r <= 1'b1;
            end
            if (halt) begin
                halt_r <= 1'b1;
            end
        end
    end

    assign imem_addr = pc;
    assign fd_in     = '{pc: pc, instr: imem_data};

    stage_reg #(.payload_t(rv_pkg::fd_payload_t)) fd_reg (
        .clk(clk), .rst(rst), .hold(stall), .flush(flush_fd || e_ebreak),
        .in_valid(!stop_r), .in_data(fd_in), .out_valid(fd_valid), .out_data(fd_q)
    );

    // ------------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------------
    instr_decoder u_decoder (
        .instr(fd_q.instr), .rs1(d_rs1), .rs2(d_rs2), .rd(d_rd), .imm(d_imm),
        .alu_op(d_alu_op), .use_imm(d_use_imm), .wb_sel(d_wb_sel), .reg_we(d_reg_we),
        .uses_rs1(d_uses_rs1), .uses_rs2(d_uses_rs2), .mem_read(d_mem_read),
        .mem_write(d_mem_write), .is_branch(d_is_branch), .is_jal(d_is_jal),
        .is_jalr(d_is_jalr), .is_ebreak(d_is_ebreak)
    );

    register_file u_regs (
        .clk(clk), .rst(rst), .raddr1(d_rs1), .raddr2(d_rs2),
        .we(mw_valid && mw_q.reg_we), .waddr(mw_q.rd), .wdata(wb_value),
        .rdata1(d_rdata1), .rdata2(d_rdata2)
    );

    assign de_in = '{pc: fd_q.pc, rdata1: d_rdata1, rdata2: d_rdata2, imm: d_imm,
                     rs1: d_rs1, rs2: d_rs2, rd: d_rd, funct3: fd_q.instr[14:12],
                     alu_op: d_alu_op, use_imm: d_use_imm, wb_sel: d_wb_sel,
                     reg_we: d_reg_we, mem_read: d_mem_read, mem_write: d_mem_write,
                     is_branch: d_is_branch, is_jal: d_is_jal, is_jalr: d_is_jalr,
                     is_ebreak: d_is_ebreak};

    stage_reg #(.payload_t(rv_pkg::de_payload_t)) de_reg (
        .clk(clk), .rst(rst), .hold(1'b0), .flush(flush_de || e_ebreak),
        .in_valid(fd_valid), .in_data(de_in), .out_valid(de_valid), .out_data(de_q)
    );

    // ------------------------------------------------------------------------
    // execute
    // ------------------------------------------------------------------------
    hazard_unit u_hazard (
        .d_rs1(d_rs1), .d_rs2(d_rs2), .d_uses_rs1(d_uses_rs1), .d_uses_rs2(d_uses_rs2),
        .e_rs1(de_q.rs1), .e_rs2(de_q.rs2), .e_rd(de_q.rd), .e_valid(de_valid),
        .e_mem_read(de_q.mem_read), .m_rd(em_q.rd), .m_valid(em_valid),
        .m_reg_we(em_q.reg_we), .w_rd(mw_q.rd), .w_valid(mw_valid),
        .w_reg_we(mw_q.reg_we), .redirect(redirect), .stall(stall),
        .flush_fd(flush_fd), .flush_de(flush_de), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    // memory answers in the same cycle, so a load forwards its data directly
    assign mem_result = em_q.mem_read ? dmem_rdata : em_q.result;

    execute_unit u_execute (
        .pc(de_q.pc), .rdata1(de_q.rdata1), .rdata2(de_q.rdata2), .imm(de_q.imm),
        .alu_op(de_q.alu_op), .use_imm(de_q.use_imm), .funct3(de_q.funct3),
        .is_branch(de_q.is_branch), .is_jal(de_q.is_jal), .is_jalr(de_q.is_jalr),
        .valid(de_valid), .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_result(mem_result),
        .wb_result(wb_value), .alu_result(alu_result), .store_data(store_data),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

    always_comb begin
        em_in            = '{pc: de_q.pc, result: alu_result, store_data: store_data,
                             rd: de_q.rd, wb_sel: de_q.wb_sel, reg_we: de_q.reg_we,
                             mem_read: de_q.mem_read, mem_write: de_q.mem_write,
                             is_ebreak: de_q.is_ebreak};
        if (de_q.wb_sel == rv_pkg::wb_pc4) begin
            em_in.result = de_q.pc + 32'd4;
        end else if (de_q.wb_sel == rv_pkg::wb_imm) begin
            em_in.result = de_q.imm;
        end
    end

    stage_reg #(.payload_t(rv_pkg::em_payload_t)) em_reg (
        .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0),
        .in_valid(de_valid), .in_data(em_in), .out_valid(em_valid), .out_data(em_q)
    );

    // ------------------------------------------------------------------------
    // memory and writeback
    // ------------------------------------------------------------------------
    assign dmem_addr  = em_q.result;
    assign dmem_wdata = em_q.store_data;
    assign dmem_we    = em_valid && em_q.mem_write;

    assign mw_in = '{pc: em_q.pc, result: em_q.result, load_data: dmem_rdata, rd: em_q.rd,
                     wb_sel: em_q.wb_sel, reg_we: em_q.reg_we, is_ebreak: em_q.is_ebreak};

    stage_reg #(.payload_t(rv_pkg::mw_payload_t)) mw_reg (
        .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0),
        .in_valid(em_valid), .in_data(mw_in), .out_valid(mw_valid), .out_data(mw_q)
    );

    assign wb_value = (mw_q.wb_sel == rv_pkg::wb_load) ? mw_q.load_data : mw_q.result;

    assign retire_valid = mw_valid;
    assign retire_pc    = mw_q.pc;
    assign retire_rd    = mw_q.reg_we ? mw_q.rd : '0;
    assign retire_data  = (mw_q.reg_we && mw_q.rd != '0) ? wb_value : '0;
    assign halt         = halt_r || (mw_valid && mw_q.is_ebreak);

    // decode never marks one instruction as both load and store
    assert property (@(posedge clk) disable iff (rst) !(dmem_we && em_q.mem_read))
        else $error("rv_core: store strobe during a load");

endmodule

/* tests/core_tb.sv */
module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int mem_words   = 256;
    localparam int max_vectors = 128;

    localparam rv_pkg::word_t boot_pc = 32'h0;

    logic              clk;
    logic              rst;
    rv_pkg::word_t     imem_addr;
    rv_pkg::word_t     imem_data;
    rv_pkg::word_t     dmem_addr;
    rv_pkg::word_t     dmem_wdata;
    rv_pkg::word_t     dmem_rdata;
    logic              dmem_we;
    logic              retire_valid;
    rv_pkg::word_t     retire_pc;
    rv_pkg::reg_addr_t retire_rd;
    rv_pkg::word_t     retire_data;
    logic              halt;

    rv_pkg::word_t imem [0:mem_words-1];
    rv_pkg::word_t dmem [0:mem_words-1];
    rv_pkg::word_t dmem_init [0:mem_words-1];

    // expected retire and store sequences, in program order
    rv_pkg::word_t exp_ret_pc [0:max_vectors-1];
    rv_pkg::word_t exp_ret_rd [0:max_vectors-1];
    rv_pkg::word_t exp_ret_data [0:max_vectors-1];
    rv_pkg::word_t exp_st_addr [0:max_vectors-1];
    rv_pkg::word_t exp_st_data [0:max_vectors-1];
    int            n_retire;
    int            n_store;
    int            retired;
    int            stored;

    rv_core #(.reset_pc(boot_pc)) uut (
        .clk(clk), .rst(rst), .imem_data(imem_data), .dmem_rdata(dmem_rdata),
        .imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we), .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_data(retire_data), .halt(halt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // memory models
    // ------------------------------------------------------------------------
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    // data memory reloads its image while reset is high
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mem_words; i++) begin
                dmem[i] <= dmem_init[i];
            end
        end else if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input rv_pkg::word_t expected,
                               input rv_pkg::word_t actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("error: %s expected %h actual %h",
                                        name, expected, actual));
        end
    endtask

    task automatic fill_memories();
        for (int i = 0; i < mem_words; i++) begin
            // opcode 0 words, no effect if ever fetched
            imem[i]      = rv_pkg::word_t'(i) << 9;
            dmem_init[i] = 32'hdada0000 ^ (rv_pkg::word_t'(i) << 2);
        end
    endtask

    task automatic load_vectors();
        int                fd;
        int                n;
        logic [7:0]        tag;
        logic [8*128-1:0]  rest;
        rv_pkg::word_t     a;
        rv_pkg::word_t     b;
        rv_pkg::word_t     c;
        fd = $fopen("tests/core_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open tests/core_vectors.txt");
        end
        n_retire = 0;
        n_store  = 0;
        while ($fscanf(fd, "%s", tag) == 1) begin
            case (tag)
                "#": n = $fgets(rest, fd);
                "I", "D": begin
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n != 2) begin
                        stop_with_failure("malformed memory line in vectors file");
                    end
                    if (tag == "I") begin
                        imem[a[9:2]] = b;
                    end else begin
                        dmem_init[a[9:2]] = b;
                    end
                end
                "R": begin
                    n = $fscanf(fd, "%h %h %h", a, b, c);
                    if (n != 3 || n_retire >= max_vectors) begin
                        stop_with_failure("malformed retire line in vectors file");
                    end
                    exp_ret_pc[n_retire]   = a;
                    exp_ret_rd[n_retire]   = b;
                    exp_ret_data[n_retire] = c;
                    n_retire++;
                end
                "S": begin
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n != 2 || n_store >= max_vectors) begin
                        stop_with_failure("malformed store line in vectors file");
                    end
                    exp_st_addr[n_store] = a;
                    exp_st_data[n_store] = b;
                    n_store++;
                end
                default: stop_with_failure($sformatf("unknown tag %s in vectors file", tag));
            endcase
        end
        $fclose(fd);
    endtask

    task automatic check_idle_outputs(input string phase);
        check_value({phase, " retire_valid"}, 32'd0, rv_pkg::word_t'(retire_valid));
        check_value({phase, " dmem_we"}, 32'd0, rv_pkg::word_t'(dmem_we));
        check_value({phase, " halt"}, 32'd0, rv_pkg::word_t'(halt));
    endtask

    task automatic check_retire();
        string label;
        if (retired >= n_retire) begin
            stop_with_failure($sformatf("extra retirement at pc %h", retire_pc));
        end
        label = $sformatf("retire %0d", retired);
        check_value({label, " pc"}, exp_ret_pc[retired], retire_pc);
        check_value({label, " rd"}, exp_ret_rd[retired], rv_pkg::word_t'(retire_rd));
        check_value({label, " data"}, exp_ret_data[retired], retire_data);
        retired++;
    endtask

    task automatic check_store();
        string label;
        if (stored >= n_store) begin
            stop_with_failure($sformatf("extra store to address %h", dmem_addr));
        end
        label = $sformatf("store %0d", stored);
        check_value({label, " addr"}, exp_st_addr[stored], dmem_addr);
        check_value({label, " data"}, exp_st_data[stored], dmem_wdata);
        stored++;
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        rst     = 1'b1;
        retired = 0;
        stored  = 0;
        fill_memories();
        load_vectors();
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs("reset");
            check_value("reset imem_addr", boot_pc, imem_addr);
        end
        rst = 1'b0;
        @(negedge clk);
        check_idle_outputs("after reset");
        // outputs settle after the rising edge, sample at the falling one
        do begin
            @(negedge clk);
            if (dmem_we) begin
                check_store();
            end
            if (retire_valid) begin
                check_retire();
            end
        end while (!halt);
        check_value("retire count at halt", rv_pkg::word_t'(n_retire), rv_pkg::word_t'(retired));
        check_value("store count at halt", rv_pkg::word_t'(n_store), rv_pkg::word_t'(stored));
        repeat (5) begin
            @(negedge clk);
            check_value("retire_valid after halt", 32'd0, rv_pkg::word_t'(retire_valid));
            check_value("halt held", 32'd1, rv_pkg::word_t'(halt));
        end
        $display("RESULT: PASS");
        $finish;
    end

    // twenty cycles per expected retirement plus slack
    initial begin
        int limit;
        @(posedge clk);
        limit = 20 * n_retire + 50;
        repeat (limit + 3) @(posedge clk);
        stop_with_failure($sformatf("timeout: core did not halt within %0d cycles", limit));
    end

endmodule

/* tests/core_vectors.txt */
# I addr word = program, D addr word = initial data
# R pc rd data = expected retire in order, S addr data = expected store in order
D 00000080 000000c8
I 00000000 123450b7
I 00000004 67808093
I 00000008 ffd00113
I 0000000c 002081b3
I 00000010 40110233
I 00000014 0041c2b3
I 00000018 0ff2f313
I 0000001c 001363b3
I 00000020 00612433
I 00000024 006134b3
I 00000028 01f41513
I 0000002c 40455593
I 00000030 00655633
I 00000034 008096b3
I 00000038 5550c013
I 0000003c 00d00733
I 00000040 08002783
I 00000044 00878833
I 00000048 09002223
I 0000004c 08b02823
I 00000050 08402883
I 00000054 01088463
I 0000005c 01089463
I 00000060 00814463
I 00000068 00815463
I 0000006c 00816463
I 00000070 00817463
I 00000078 00245463
I 00000080 00246463
I 00000088 00240463
I 0000008c 00244463
I 00000090 00241463
I 00000098 00247463
I 0000009c 00c00a6f
I 000000a8 011a0ae7
I 000000b0 014a8b33
I 000000b4 00100073
R 00000000 01 12345000
R 00000004 01 12345678
R 00000008 02 fffffffd
R 0000000c 03 12345675
R 00000010 04 edcba985
R 00000014 05 fffffff0
R 00000018 06 000000f0
R 0000001c 07 123456f8
R 00000020 08 00000001
R 00000024 09 00000000
R 00000028 0a 80000000
R 0000002c 0b f8000000
R 00000030 0c 00008000
R 00000034 0d 2468acf0
R 00000038 00 00000000
R 0000003c 0e 2468acf0
R 00000040 0f 000000c8
R 00000044 10 000000c9
R 00000048 00 00000000
R 0000004c 00 00000000
R 00000050 11 000000c9
R 00000054 00 00000000
R 0000005c 00 00000000
R 00000060 00 00000000
R 00000068 00 00000000
R 0000006c 00 00000000
R 00000070 00 00000000
R 00000078 00 00000000
R 00000080 00 00000000
R 00000088 00 00000000
R 0000008c 00 00000000
R 00000090 00 00000000
R 00000098 00 00000000
R 0000009c 14 000000a0
R 000000a8 15 000000ac
R 000000b0 16 0000014c
R 000000b4 00 00000000
S 00000084 000000c9
S 00000090 f8000000

/* filelist.f */
logic/rv_pkg.sv
logic/stage_reg.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/execute_unit.sv
logic/hazard_unit.sv
logic/rv_core.sv
tests/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
